// ==== files.f ====
source/cart_pkg.sv
source/header_detect.sv
source/ram_clear.sv
source/cheat_assembler.sv
source/cart_loader.sv
bench/cart_loader_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cart_loader_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/cart_loader_tb.sv ====
`timescale 1ns/1ps

module cart_loader_tb;

	localparam int SWEEP_LEN = 1 << cart_pkg::FILL_ADDR_BITS;

	logic                   clk_sys;
	logic                   RESET;
	cart_pkg::dl_bus_t      dl;
	cart_pkg::header_mode_t header_mode;
	cart_pkg::region_sel_t  region_sel;
	logic [1:0]             fill_sel;
	cart_pkg::cart_info_t   cart;
	logic                   pal;
	cart_pkg::fill_wr_t     fill;
	logic                   clearing;
	cart_pkg::cheat_t       cheat;
	logic                   cheat_valid;
	logic                   cheat_clear;
	logic                   core_reset;

	logic [31:0]        lfsr = 32'hb3ef;
	logic               timed_out = 1'b0;
	string              test_name;
	int                 test_errors = 0;
	int                 total_errors = 0;
	int                 checks = 0;
	int                 tests = 0;
	cart_pkg::dl_addr_t img_addr[$];
	cart_pkg::dl_word_t img_data[$];

	cart_loader #(.COPIER_SKIP(512)) i_cart_loader (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Ends the run once a wait has given up
	initial begin
		wait (timed_out);
		$display("*** FAILED ***");
		$finish;
	end

	// ========================================================================
	// Reference model
	// ========================================================================

	// Fibonacci LFSR with taps 32 22 2 1
	// One step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// 2^(size+10) - 1 kept to 24 bits
	function automatic logic [23:0] size_mask(input logic [3:0] code);
		logic [31:0] span;
		span = 32'd1 << (code + 10);
		return span[23:0] - 24'd1;
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [1:0] sel, input logic [16:0] a);
		if (sel == 2'd0)
			return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
		if (sel == 2'd1)
			return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
		return (sel == 2'd2) ? 8'h55 : 8'hFF;
	endfunction

	// ========================================================================
	// Checks and stimulus
	// ========================================================================

	task automatic check_value(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic finish_test();
		$display("test %s done, %0d errors", test_name, test_errors);
		tests++;
		test_errors = 0;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout in %s: %s did not happen in time", test_name, what);
		timed_out = 1'b1;
		forever @(posedge clk_sys);
	endtask

	task automatic check_idle_outputs(input logic reset_expected);
		check_value("fill.en", 0, fill.en);
		check_value("clearing", 0, clearing);
		check_value("cheat_valid", 0, cheat_valid);
		check_value("cheat_clear", 0, cheat_clear);
		check_value("pal", 0, pal);
		check_value("cart", 0, cart);
		check_value("core_reset", reset_expected, core_reset);
	endtask

	// Cart download of the queued image at one write per cycle
	task automatic send_image();
		int i;
		for (i = 0; i < img_addr.size(); i++) begin
			@(negedge clk_sys);
			if (i > 0) begin
				check_value("cheat_clear in load", 1, cheat_clear);
				check_value("core_reset in load", 1, core_reset);
			end
			dl.active = 1'b1;
			dl.index  = {2'(random_bits(2)), 6'd0};
			dl.addr   = img_addr[i];
			dl.data   = img_data[i];
			dl.wr     = 1'b1;
		end
		@(negedge clk_sys);
		dl = '0;
	endtask

	// Download one image and compare cart info with the header rules
	task automatic header_case(input cart_pkg::header_mode_t mode, input logic [15:0] word0,
			output logic region);
		cart_pkg::dl_addr_t at;
		logic [15:0]        size_word;
		logic [3:0]         rom_s;
		logic [3:0]         ram_s;
		logic [7:0]         rom_type;
		int                 n;
		int                 i;
		img_addr.delete();
		img_data.delete();
		region = 1'(random_bits(1));
		img_addr.push_back(25'd0);
		img_data.push_back(word0);
		img_addr.push_back(25'd2);
		img_data.push_back({7'(random_bits(7)), region, 8'(random_bits(8))});
		rom_s = 4'hC;
		ram_s = 4'h0;
		case (mode)
			cart_pkg::LOROM:   at = 25'h007FD6;
			cart_pkg::HIROM:   at = 25'h00FFD6;
			cart_pkg::EXHIROM: at = 25'h40FFD6;
			default:           at = 25'd0;
		endcase
		rom_type = (mode == cart_pkg::HIROM) ? 8'd1 : (mode == cart_pkg::EXHIROM) ? 8'd2 : 8'd0;
		if (mode == cart_pkg::AUTO) begin
			rom_type = word0[15:8];
			if (word0[7:0] != 8'h00)
				{ram_s, rom_s} = word0[7:0];
		end
		if (at != 25'd0) begin
			// Copier header shifts the size words
			at        = at + 25'd512;
			size_word = 16'(random_bits(16));
			rom_s     = size_word[11:8];
			img_addr.push_back(at);
			img_data.push_back(size_word);
			size_word = 16'(random_bits(16));
			ram_s     = size_word[3:0];
			img_addr.push_back(at + 25'd2);
			img_data.push_back(size_word);
		end
		n = 18 + int'(random_bits(3));
		for (i = 0; i < n; i++) begin
			img_addr.push_back(at + 25'd4 + 25'(2 * i));
			img_data.push_back(16'(random_bits(16)));
		end
		@(negedge clk_sys);
		header_mode = mode;
		send_image();
		check_value("rom_type", rom_type, cart.rom_type);
		check_value("rom_mask", size_mask(rom_s), cart.rom_mask);
		check_value("ram_mask", (ram_s == 4'h0) ? 24'd0 : size_mask(ram_s), cart.ram_mask);
	endtask

	task automatic ram_clear_test();
		int count;
		int guard;
		guard = 0;
		while (clearing && guard < SWEEP_LEN + 16) begin
			@(negedge clk_sys);
			guard++;
		end
		if (clearing)
			report_timeout("end of the earlier WRAM sweep");
		fill_sel  = 2'(random_bits(2));
		dl.active = 1'b1;
		// Before the next edge only the download term holds the core in reset
		#5;
		check_value("clearing before sweep", 0, clearing);
		check_value("core_reset before sweep", 1, core_reset);
		@(negedge clk_sys);
		count = 0;
		guard = 0;
		while (clearing && guard < SWEEP_LEN + 16) begin
			check_value("core_reset", 1, core_reset);
			check_value("fill.en", 1, fill.en);
			check_value("fill.addr", count[16:0], fill.addr);
			check_value("fill.data", fill_pattern(fill_sel, count[16:0]), fill.data);
			dl = '0;
			count++;
			guard++;
			@(negedge clk_sys);
		end
		if (clearing)
			report_timeout("end of the WRAM sweep");
		check_value("fill write count", SWEEP_LEN, count);
		check_value("fill.en after sweep", 0, fill.en);
	endtask

	task automatic cheat_test();
		logic [15:0]        w[8];
		logic [127:0]       expected;
		cart_pkg::dl_addr_t base;
		cart_pkg::dl_addr_t prev;
		int                 r;
		int                 k;
		int                 pulses;
		prev = '1;
		for (r = 0; r < 5; r++) begin
			base = (r == 0) ? 25'd0 : {21'(random_bits(21)), 4'd0};
			for (k = 0; k < 8; k++)
				w[k] = 16'(random_bits(16));
			expected = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
			for (k = 0; k < 8; k++) begin
				@(negedge clk_sys);
				check_value("cheat_clear", k > 0 && prev == '0, cheat_clear);
				check_value("early cheat_valid", 0, cheat_valid);
				prev      = base + 25'(2 * k);
				dl.active = 1'b1;
				dl.index  = 8'hFF;
				dl.addr   = prev;
				dl.data   = w[k];
				dl.wr     = 1'b1;
			end
			// One valid pulse expected in the idle cycles
			pulses = 0;
			for (k = 0; k < 6; k++) begin
				@(negedge clk_sys);
				dl = '0;
				if (cheat_valid) begin
					pulses++;
					check_value("cheat record", expected, cheat);
				end
			end
			check_value("cheat_valid pulses", 1, pulses);
		end
	endtask

	initial begin
		logic        region;
		logic [15:0] word;
		int          n;
		RESET       = 1'b1;
		dl          = '0;
		header_mode = cart_pkg::AUTO;
		region_sel  = cart_pkg::REGION_AUTO;
		fill_sel    = 2'd0;

		test_name = "reset_state";
		repeat (16) begin
			@(negedge clk_sys);
			check_idle_outputs(1'b1);
		end
		RESET = 1'b0;
		@(negedge clk_sys);
		check_idle_outputs(1'b0);
		finish_test();

		test_name = "auto_header";
		for (n = 0; n < 4; n++) begin
			word = 16'(random_bits(16));
			if (word[7:0] == 8'h00)
				word[0] = 1'b1;
			header_case(cart_pkg::AUTO, word, region);
		end
		word      = 16'(random_bits(16));
		word[7:0] = 8'h00;
		header_case(cart_pkg::AUTO, word, region);
		finish_test();

		test_name = "forced_modes";
		header_case(cart_pkg::NO_HEADER, 16'(random_bits(16)), region);
		header_case(cart_pkg::LOROM, 16'(random_bits(16)), region);
		header_case(cart_pkg::HIROM, 16'(random_bits(16)), region);
		header_case(cart_pkg::EXHIROM, 16'(random_bits(16)), region);
		finish_test();

		test_name = "region";
		for (n = 0; n < 6; n++) begin
			@(negedge clk_sys);
			region_sel = cart_pkg::region_sel_t'(n % 3);
			header_case(cart_pkg::AUTO, 16'(random_bits(16)), region);
			repeat (2) @(negedge clk_sys);
			check_value("pal", (n % 3 == 0) ? region : (n % 3 == 2), pal);
		end
		finish_test();

		test_name = "ram_clear";
		ram_clear_test();
		finish_test();

		test_name = "cheats";
		cheat_test();
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, total_errors);
		if (total_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== source/cart_loader.sv ====
`timescale 1ns/1ps

module cart_loader #(
	parameter int COPIER_SKIP = 512
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  cart_pkg::dl_bus_t       dl,
	input  cart_pkg::header_mode_t  header_mode,
	input  cart_pkg::region_sel_t   region_sel,
	input  logic [1:0]              fill_sel,
	output cart_pkg::cart_info_t    cart,
	output logic                    pal,
	output cart_pkg::fill_wr_t      fill,
	output logic                    clearing,
	output cart_pkg::cheat_t        cheat,
	output logic                    cheat_valid,
	output logic                    cheat_clear,
	output logic                    core_reset
);

	logic cart_dl;
	logic cheat_dl;

	// ========================================================================
	// Index decode and core reset
	// ========================================================================

	assign cart_dl  = dl.active && dl.index[5:0] == cart_pkg::IDX_CART[5:0];
	assign cheat_dl = dl.active && dl.index == cart_pkg::IDX_CHEAT;

	// Core held off while loading and while WRAM is swept
	assign core_reset = RESET | cart_dl | clearing;

	header_detect #(
		.COPIER_SKIP (COPIER_SKIP)
	) i_header_detect (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_dl     (cart_dl),
		.dl          (dl),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.cart        (cart),
		.pal         (pal)
	);

	ram_clear i_ram_clear (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.cart_dl  (cart_dl),
		.fill_sel (fill_sel),
		.fill     (fill),
		.clearing (clearing)
	);

	cheat_assembler i_cheat_assembler (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cheat_dl    (cheat_dl),
		.cart_dl     (cart_dl),
		.dl          (dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

// ==== source/cheat_assembler.sv ====
`timescale 1ns/1ps

module cheat_assembler (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               cheat_dl,
	input  logic               cart_dl,
	input  cart_pkg::dl_bus_t  dl,
	output cart_pkg::cheat_t   cheat,
	output logic               cheat_valid,
	output logic               cheat_clear
);

	logic cheat_wr;

	assign cheat_wr = cheat_dl & dl.wr;

	// ========================================================================
	// Record assembly, low word of each field first
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= dl.data;
				4'd2:  cheat.flags[31:16]   <= dl.data;
				4'd4:  cheat.address[15:0]  <= dl.data;
				4'd6:  cheat.address[31:16] <= dl.data;
				4'd8:  cheat.compare[15:0]  <= dl.data;
				4'd10: cheat.compare[31:16] <= dl.data;
				4'd12: cheat.replace[15:0]  <= dl.data;
				4'd14: cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// Strobes
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word completes the record
			cheat_valid <= cheat_wr && dl.addr[3:0] == 4'd14;
			// Table restarts on a fresh cheat file or any new cartridge
			cheat_clear <= (cheat_wr && dl.addr == '0) || cart_dl;
		end
	end

endmodule

// ==== source/ram_clear.sv ====
`timescale 1ns/1ps

module ram_clear (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                cart_dl,
	input  logic [1:0]          fill_sel,
	output cart_pkg::fill_wr_t  fill,
	output logic                clearing
);

	typedef enum logic {
		IDLE,
		SWEEP
	} clear_state_t;

	clear_state_t         state;
	logic                 cart_dl_q;
	cart_pkg::fill_addr_t addr;
	cart_pkg::byte_t      pattern;

	// ========================================================================
	// Sweep sequencer
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= IDLE;
			cart_dl_q <= 1'b0;
			addr      <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q) begin
				// New cartridge, start from the bottom
				state <= SWEEP;
				addr  <= '0;
			end else if (state == SWEEP) begin
				addr <= addr + 1'b1;
				if (&addr)
					state <= IDLE;
			end else begin
				addr <= '0;
			end
		end
	end

	// Power-on patterns seen on real consoles
	always_comb begin
		case (fill_sel)
			2'd0:    pattern = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			2'd1:    pattern = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			2'd2:    pattern = 8'h55;
			default: pattern = 8'hFF;
		endcase
	end

	assign clearing = (state == SWEEP);

	always_comb begin
		fill.addr = addr;
		fill.data = pattern;
		fill.en   = clearing;
	end

endmodule

// ==== source/header_detect.sv ====
`timescale 1ns/1ps

module header_detect #(
	parameter int COPIER_SKIP = 512
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_dl,
	input  cart_pkg::dl_bus_t       dl,
	input  cart_pkg::header_mode_t  header_mode,
	input  cart_pkg::region_sel_t   region_sel,
	output cart_pkg::cart_info_t    cart,
	output logic                    pal
);

	cart_pkg::size_code_t rom_size;
	cart_pkg::size_code_t ram_size;
	logic                 rom_region;

	// Size word location for the forced modes
	cart_pkg::dl_addr_t hdr_rom_addr;
	cart_pkg::dl_addr_t hdr_ram_addr;
	logic               hdr_forced;

	logic cart_wr;

	function automatic cart_pkg::mask_t size_to_mask(input cart_pkg::size_code_t code);
		return (24'd1024 << code) - 24'd1;
	endfunction

	assign cart_wr = cart_dl & dl.wr;

	always_comb begin
		hdr_forced   = 1'b1;
		hdr_rom_addr = '0;
		case (header_mode)
			cart_pkg::LOROM:   hdr_rom_addr = cart_pkg::dl_addr_t'(cart_pkg::HDR_LOROM_SIZE);
			cart_pkg::HIROM:   hdr_rom_addr = cart_pkg::dl_addr_t'(cart_pkg::HDR_HIROM_SIZE);
			cart_pkg::EXHIROM: hdr_rom_addr = cart_pkg::dl_addr_t'(cart_pkg::HDR_EXHIROM_SIZE);
			default:           hdr_forced   = 1'b0;
		endcase
		hdr_rom_addr = hdr_rom_addr + cart_pkg::dl_addr_t'(COPIER_SKIP);
		hdr_ram_addr = hdr_rom_addr + 25'd2;
	end

	// ========================================================================
	// Header capture
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			cart       <= '0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (cart_wr) begin
				if (dl.addr == '0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					// Size nibbles packed in the low byte of a tagged image
					if (header_mode == cart_pkg::AUTO && dl.data[7:0] != 8'h00)
						{ram_size, rom_size} <= dl.data[7:0];

					case (header_mode)
						cart_pkg::NO_HEADER: cart.rom_type <= 8'd0;
						cart_pkg::LOROM:     cart.rom_type <= 8'd0;
						cart_pkg::HIROM:     cart.rom_type <= 8'd1;
						cart_pkg::EXHIROM:   cart.rom_type <= 8'd2;
						default:             cart.rom_type <= dl.data[15:8];
					endcase
				end

				if (dl.addr == 25'd2)
					rom_region <= dl.data[8];

				if (hdr_forced && dl.addr == hdr_rom_addr)
					rom_size <= dl.data[11:8];
				if (hdr_forced && dl.addr == hdr_ram_addr)
					ram_size <= dl.data[3:0];

				// Uses the sizes as they stood before this write
				cart.rom_mask <= size_to_mask(rom_size);
				cart.ram_mask <= (ram_size == '0) ? '0 : size_to_mask(ram_size);
			end
		end else begin
			case (region_sel)
				cart_pkg::REGION_NTSC: pal <= 1'b0;
				cart_pkg::REGION_PAL:  pal <= 1'b1;
				default:               pal <= rom_region;
			endcase
		end
	end

endmodule

// ==== source/cart_pkg.sv ====
package cart_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int FILL_ADDR_BITS = 17;

	typedef logic [24:0]               dl_addr_t;
	typedef logic [15:0]               dl_word_t;
	typedef logic [23:0]               mask_t;
	typedef logic [3:0]                size_code_t;
	typedef logic [FILL_ADDR_BITS-1:0] fill_addr_t;
	typedef logic [7:0]                byte_t;

	// Download indexes (cart is matched on the low 6 bits only)
	localparam logic [7:0] IDX_CART  = 8'h00;
	localparam logic [7:0] IDX_CHEAT = 8'hFF;

	// Size byte offsets inside the image, RAM size sits two bytes later
	localparam mask_t HDR_LOROM_SIZE   = 24'h7FD6;
	localparam mask_t HDR_HIROM_SIZE   = 24'hFFD6;
	localparam mask_t HDR_EXHIROM_SIZE = 24'h40FFD6;

	// ========================================================================
	// Settings
	// ========================================================================

	typedef enum logic [2:0] {
		AUTO      = 3'd0,
		NO_HEADER = 3'd1,
		LOROM     = 3'd2,
		HIROM     = 3'd3,
		EXHIROM   = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_t;

	// ========================================================================
	// Bundles
	// ========================================================================

	typedef struct packed {
		logic       active;
		logic [7:0] index;
		dl_addr_t   addr;
		dl_word_t   data;
		logic       wr;
	} dl_bus_t;

	typedef struct packed {
		logic [7:0] rom_type;
		mask_t      rom_mask;
		mask_t      ram_mask;
	} cart_info_t;

	typedef struct packed {
		fill_addr_t addr;
		byte_t      data;
		logic       en;
	} fill_wr_t;

	// Same bit layout as the cheat engine expects: flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_t;

endpackage
